// File: logic/simd_alu.sv
module simd_alu (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     valid_i,
  input  simd_alu_pkg::simd_req_t  req_i,
  input  simd_alu_pkg::simd_word_t operand_a_i,
  input  simd_alu_pkg::simd_word_t operand_b_i,
  output logic                     valid_o,
  output simd_alu_pkg::simd_rsp_t  rsp_o
);
  import simd_alu_pkg::*;

  simd_word_t opa;
  simd_word_t opb;
  strb_t      less;
  strb_t      equal;
  strb_t      pick_a;
  strb_t      cmp_flag;
  simd_rsp_t  arith_rsp;
  simd_word_t shift_res;
  simd_word_t local_res;
  simd_rsp_t  rsp_d;

  assign opa = operand_a_i;
  assign opb = operand_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////////////////////

  simd_compare simd_compare_i (
    .op_i        ( req_i.op    ),
    .vew_i       ( req_i.vew   ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .less_o      ( less        ),
    .equal_o     ( equal       )
  );

  simd_arith simd_arith_i (
    .req_i       ( req_i       ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .rsp_o       ( arith_rsp   )
  );

  simd_shift simd_shift_i (
    .op_i        ( req_i.op    ),
    .vew_i       ( req_i.vew   ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .result_o    ( shift_res   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Local ops
  ////////////////////////////////////////////////////////////////////////////

  // Lanes taking A, for merge and min/max alike
  always_comb begin : p_pick
    unique case (req_i.op)
      VMERGE:      pick_a = req_i.mask;
      VMAX, VMAXU: pick_a = less;
      default:     pick_a = ~less;
    endcase
  end : p_pick

  always_comb begin : p_cmp_flag
    unique case (req_i.op)
      VMSEQ:          cmp_flag = equal;
      VMSNE:          cmp_flag = ~equal;
      VMSLT, VMSLTU:  cmp_flag = less;
      VMSLE, VMSLEU:  cmp_flag = less | equal;
      default:        cmp_flag = ~(less | equal);
    endcase
  end : p_cmp_flag

  always_comb begin : p_local
    local_res = '0;
    unique case (req_i.op)
      VAND: local_res = opa & opb;
      VOR:  local_res = opa | opb;
      VXOR: local_res = opa ^ opb;
      VMERGE, VMIN, VMINU, VMAX, VMAXU: begin
        unique case (req_i.vew)
          EW8: for (int e = 0; e < 8; e++) begin
            local_res.w8[e] = pick_a[e] ? opa.w8[e] : opb.w8[e];
          end
          EW16: for (int e = 0; e < 4; e++) begin
            local_res.w16[e] = pick_a[2*e] ? opa.w16[e] : opb.w16[e];
          end
          EW32: for (int e = 0; e < 2; e++) begin
            local_res.w32[e] = pick_a[4*e] ? opa.w32[e] : opb.w32[e];
          end
          EW64: local_res.w64[0] = pick_a[0] ? opa.w64[0] : opb.w64[0];
        endcase
      end
      // {mask bit, flag} in the two low bits of each element
      VMSEQ, VMSNE, VMSLT, VMSLTU, VMSLE, VMSLEU, VMSGT, VMSGTU: begin
        unique case (req_i.vew)
          EW8: for (int e = 0; e < 8; e++) begin
            local_res.w8[e] = 8'({req_i.mask[e], cmp_flag[e]});
          end
          EW16: for (int e = 0; e < 4; e++) begin
            local_res.w16[e] = 16'({req_i.mask[2*e], cmp_flag[2*e]});
          end
          EW32: for (int e = 0; e < 2; e++) begin
            local_res.w32[e] = 32'({req_i.mask[4*e], cmp_flag[4*e]});
          end
          EW64: local_res.w64[0] = 64'({req_i.mask[0], cmp_flag[0]});
        endcase
      end
      default: ;
    endcase
  end : p_local

  // Units are zero outside their own ops
  assign rsp_d.result = local_res | arith_rsp.result | shift_res;
  assign rsp_d.vxsat  = arith_rsp.vxsat;

  ////////////////////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
      rsp_o   <= '0;
    end else begin
      valid_o <= valid_i;
      // Result holds while idle
      if (valid_i)
        rsp_o <= rsp_d;
    end
  end

endmodule

// File: logic/simd_alu_config.svh
`ifndef SIMD_ALU_CONFIG_SVH
`define SIMD_ALU_CONFIG_SVH

// One 64-bit word per cycle
`define SIMD_DATA_WIDTH 64

// One strobe bit per byte lane of the word
`define SIMD_STRB_WIDTH 8

`endif

// File: logic/simd_alu_pkg.sv
`include "simd_alu_config.svh"

package simd_alu_pkg;

  // Vector ALU operations
  typedef enum logic [4:0] {
    // Bitwise
    VAND, VOR, VXOR,
    // Modular add/sub and carry forms
    VADD, VADC, VMADC, VSUB, VSBC, VMSBC, VRSUB,
    // Saturating add/sub
    VSADDU, VSADD, VSSUBU, VSSUB,
    // Shifts
    VSLL, VSRL, VSRA,
    // Min and max
    VMIN, VMINU, VMAX, VMAXU,
    // Compare to mask
    VMSEQ, VMSNE, VMSLT, VMSLTU, VMSLE, VMSLEU, VMSGT, VMSGTU,
    // Merge under mask
    VMERGE
  } alu_op_e;

  // Element width
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Byte-lane vector, one bit per byte of the datapath
  typedef logic [`SIMD_STRB_WIDTH-1:0] strb_t;

  // Same word seen per element width
  typedef union packed {
    logic [0:0][`SIMD_DATA_WIDTH-1:0]   w64;
    logic [1:0][`SIMD_DATA_WIDTH/2-1:0] w32;
    logic [3:0][`SIMD_DATA_WIDTH/4-1:0] w16;
    logic [7:0][`SIMD_DATA_WIDTH/8-1:0] w8;
  } simd_word_t;

  // Control fields of one request
  typedef struct packed {
    alu_op_e op;
    vew_e    vew;
    logic    vm;    // high when unmasked
    strb_t   mask;
  } simd_req_t;

  // One response word with its saturation lanes
  typedef struct packed {
    simd_word_t result;
    strb_t      vxsat;
  } simd_rsp_t;

endpackage

// File: logic/simd_arith.sv
`include "simd_alu_config.svh"

module simd_arith (
  input  simd_alu_pkg::simd_req_t  req_i,
  input  simd_alu_pkg::simd_word_t operand_a_i,
  input  simd_alu_pkg::simd_word_t operand_b_i,
  output simd_alu_pkg::simd_rsp_t  rsp_o
);
  import simd_alu_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Element arithmetic
  ////////////////////////////////////////////////////////////////////////////

  // Element of w bits held zero-extended, returns {saturated, result}
  function automatic logic [`SIMD_DATA_WIDTH:0] lane_calc(
    input alu_op_e                     op,
    input logic [`SIMD_DATA_WIDTH-1:0] a,
    input logic [`SIMD_DATA_WIDTH-1:0] b,
    input logic                        cin,
    input int unsigned                 w
  );
    logic [`SIMD_DATA_WIDTH:0]   wide;
    logic [`SIMD_DATA_WIDTH-1:0] keep;
    logic [`SIMD_DATA_WIDTH-1:0] res;
    logic                        carry;
    logic                        sign_a;
    logic                        sign_b;
    logic                        sign_r;
    logic                        sat;

    keep = {`SIMD_DATA_WIDTH{1'b1}} >> (`SIMD_DATA_WIDTH - w);

    // One bit wider than the element, so bit w is carry or borrow
    unique case (op)
      VSUB, VSBC, VMSBC, VSSUBU, VSSUB: wide = {1'b0, b} - {1'b0, a} - cin;
      VRSUB:                            wide = {1'b0, a} - {1'b0, b};
      default:                          wide = {1'b0, a} + {1'b0, b} + cin;
    endcase

    carry  = wide[w];
    sign_a = a[w-1];
    sign_b = b[w-1];
    sign_r = wide[w-1];
    res    = wide[`SIMD_DATA_WIDTH-1:0] & keep;
    sat    = 1'b0;

    unique case (op)
      VMADC, VMSBC: begin
        res = {{(`SIMD_DATA_WIDTH-2){1'b0}}, 1'b1, carry};
      end
      VSADDU: begin
        sat = carry;
        if (sat)
          res = keep;
      end
      VSSUBU: begin
        sat = carry;
        if (sat)
          res = '0;
      end
      VSADD: begin
        // Same-sign addends whose sum flipped sign
        sat = (sign_a == sign_b) && (sign_r != sign_a);
        if (sat)
          res = sign_a ? ~(keep >> 1) & keep : keep >> 1;
      end
      VSSUB: begin
        // b - a can only overflow when the signs differ
        sat = (sign_a != sign_b) && (sign_r != sign_b);
        if (sat)
          res = sign_b ? ~(keep >> 1) & keep : keep >> 1;
      end
      default: ;
    endcase

    return {sat, res};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Per-width dispatch
  ////////////////////////////////////////////////////////////////////////////

  simd_word_t                opa;
  simd_word_t                opb;
  simd_word_t                res;
  strb_t                     vxsat;
  logic                      is_arith;
  logic                      cin_en;
  logic [`SIMD_DATA_WIDTH:0] lane;

  assign opa = operand_a_i;
  assign opb = operand_b_i;

  assign is_arith = req_i.op inside {VADD, VADC, VMADC, VSUB, VSBC, VMSBC, VRSUB,
                                     VSADDU, VSADD, VSSUBU, VSSUB};
  // Carry/borrow-in from the mask only in the masked encoding
  assign cin_en = (req_i.op inside {VADC, VMADC, VSBC, VMSBC}) && !req_i.vm;

  always_comb begin : p_arith
    res   = '0;
    vxsat = '0;
    lane  = '0;
    if (is_arith) begin
      unique case (req_i.vew)
        EW8: for (int e = 0; e < 8; e++) begin
          lane            = lane_calc(req_i.op, opa.w8[e], opb.w8[e],
                                      cin_en & req_i.mask[e], 8);
          res.w8[e]       = lane[7:0];
          vxsat[e]        = lane[`SIMD_DATA_WIDTH];
        end
        EW16: for (int e = 0; e < 4; e++) begin
          lane            = lane_calc(req_i.op, opa.w16[e], opb.w16[e],
                                      cin_en & req_i.mask[2*e], 16);
          res.w16[e]      = lane[15:0];
          vxsat[2*e +: 2] = {2{lane[`SIMD_DATA_WIDTH]}};
        end
        EW32: for (int e = 0; e < 2; e++) begin
          lane            = lane_calc(req_i.op, opa.w32[e], opb.w32[e],
                                      cin_en & req_i.mask[4*e], 32);
          res.w32[e]      = lane[31:0];
          vxsat[4*e +: 4] = {4{lane[`SIMD_DATA_WIDTH]}};
        end
        EW64: begin
          lane            = lane_calc(req_i.op, opa.w64[0], opb.w64[0],
                                      cin_en & req_i.mask[0], 64);
          res.w64[0]      = lane[63:0];
          vxsat           = {8{lane[`SIMD_DATA_WIDTH]}};
        end
      endcase
    end
  end : p_arith

  assign rsp_o.result = res;
  assign rsp_o.vxsat  = vxsat;

endmodule

// File: logic/simd_compare.sv
module simd_compare (
  input  simd_alu_pkg::alu_op_e    op_i,
  input  simd_alu_pkg::vew_e       vew_i,
  input  simd_alu_pkg::simd_word_t operand_a_i,
  input  simd_alu_pkg::simd_word_t operand_b_i,
  output simd_alu_pkg::strb_t      less_o,
  output simd_alu_pkg::strb_t      equal_o
);
  import simd_alu_pkg::*;

  simd_word_t opa;
  simd_word_t opb;
  logic       is_cmp;
  logic       sgn;
  strb_t      less;
  strb_t      equal;

  assign opa = operand_a_i;
  assign opb = operand_b_i;

  assign is_cmp = op_i inside {VMIN, VMINU, VMAX, VMAXU, VMSEQ, VMSNE, VMSLT, VMSLTU,
                               VMSLE, VMSLEU, VMSGT, VMSGTU};
  // Signed ops extend with the element MSB, the rest with zero
  assign sgn = op_i inside {VMIN, VMAX, VMSLT, VMSLE, VMSGT};

  // Flag of each element lands on its lowest byte lane
  always_comb begin : p_flags
    less  = '0;
    equal = '0;
    unique case (vew_i)
      EW8: for (int e = 0; e < 8; e++) begin
        less[e]    = $signed({sgn & opb.w8[e][7], opb.w8[e]}) <
                     $signed({sgn & opa.w8[e][7], opa.w8[e]});
        equal[e]   = opa.w8[e] == opb.w8[e];
      end
      EW16: for (int e = 0; e < 4; e++) begin
        less[2*e]  = $signed({sgn & opb.w16[e][15], opb.w16[e]}) <
                     $signed({sgn & opa.w16[e][15], opa.w16[e]});
        equal[2*e] = opa.w16[e] == opb.w16[e];
      end
      EW32: for (int e = 0; e < 2; e++) begin
        less[4*e]  = $signed({sgn & opb.w32[e][31], opb.w32[e]}) <
                     $signed({sgn & opa.w32[e][31], opa.w32[e]});
        equal[4*e] = opa.w32[e] == opb.w32[e];
      end
      EW64: begin
        less[0]    = $signed({sgn & opb.w64[0][63], opb.w64[0]}) <
                     $signed({sgn & opa.w64[0][63], opa.w64[0]});
        equal[0]   = opa.w64[0] == opb.w64[0];
      end
    endcase
  end : p_flags

  assign less_o  = is_cmp ? less : '0;
  assign equal_o = is_cmp ? equal : '0;

endmodule

// File: logic/simd_shift.sv
module simd_shift (
  input  simd_alu_pkg::alu_op_e    op_i,
  input  simd_alu_pkg::vew_e       vew_i,
  input  simd_alu_pkg::simd_word_t operand_a_i,
  input  simd_alu_pkg::simd_word_t operand_b_i,
  output simd_alu_pkg::simd_word_t result_o
);
  import simd_alu_pkg::*;

  simd_word_t opa;
  simd_word_t opb;
  simd_word_t res;
  logic       is_shift;

  assign opa = operand_a_i;
  assign opb = operand_b_i;

  assign is_shift = op_i inside {VSLL, VSRL, VSRA};

  // B shifted by the low log2(width) bits of A
  always_comb begin : p_shift
    res = '0;
    if (is_shift) begin
      unique case (vew_i)
        EW8: for (int e = 0; e < 8; e++) begin
          unique case (op_i)
            VSLL:    res.w8[e] = opb.w8[e] << opa.w8[e][2:0];
            VSRL:    res.w8[e] = opb.w8[e] >> opa.w8[e][2:0];
            default: res.w8[e] = $signed(opb.w8[e]) >>> opa.w8[e][2:0];
          endcase
        end
        EW16: for (int e = 0; e < 4; e++) begin
          unique case (op_i)
            VSLL:    res.w16[e] = opb.w16[e] << opa.w16[e][3:0];
            VSRL:    res.w16[e] = opb.w16[e] >> opa.w16[e][3:0];
            default: res.w16[e] = $signed(opb.w16[e]) >>> opa.w16[e][3:0];
          endcase
        end
        EW32: for (int e = 0; e < 2; e++) begin
          unique case (op_i)
            VSLL:    res.w32[e] = opb.w32[e] << opa.w32[e][4:0];
            VSRL:    res.w32[e] = opb.w32[e] >> opa.w32[e][4:0];
            default: res.w32[e] = $signed(opb.w32[e]) >>> opa.w32[e][4:0];
          endcase
        end
        EW64: begin
          unique case (op_i)
            VSLL:    res.w64[0] = opb.w64[0] << opa.w64[0][5:0];
            VSRL:    res.w64[0] = opb.w64[0] >> opa.w64[0][5:0];
            default: res.w64[0] = $signed(opb.w64[0]) >>> opa.w64[0][5:0];
          endcase
        end
      endcase
    end
  end : p_shift

  assign result_o = res;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SIMD ALU testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module tb_simd_alu \
  -f simd_alu.f -Mdir "$BUILD_DIR" -o Vtb_simd_alu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_simd_alu" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
  exit 0
fi
exit 1

// File: simd_alu.f
+incdir+logic
logic/simd_alu_pkg.sv
logic/simd_compare.sv
logic/simd_arith.sv
logic/simd_shift.sv
logic/simd_alu.sv
tb/simd_alu_checker.sv
tb/tb_simd_alu.sv

// File: tb/simd_alu_checker.sv
module simd_alu_checker (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_valid_i,
  input  simd_alu_pkg::simd_req_t req_i,
  input  simd_alu_pkg::simd_rsp_t exp_rsp_i,
  input  logic                    dut_valid_i,
  input  simd_alu_pkg::simd_rsp_t dut_rsp_i,
  output int                      pass_cnt_o,
  output int                      fail_cnt_o,
  output int                      pending_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import simd_alu_pkg::*;

  typedef struct packed {
    logic [15:0] idx;
    simd_req_t   req;
    simd_rsp_t   rsp;
  } pend_t;

  pend_t     pend_q[$];
  simd_rsp_t last_rsp   = '0;
  logic      reset_done = 1'b0;
  int        pass_cnt   = 0;
  int        fail_cnt   = 0;
  int        push_cnt   = 0;
  int        pending    = 0;

  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;
  assign pending_o  = pending;

  task automatic check_reset();
    logic ok;
    ok = 1'b1;
    if (dut_valid_i !== 1'b0) begin
      $display("CHECK FAILED t=%0t valid_o expected 0 got %b", $time, dut_valid_i);
      ok = 1'b0;
    end
    if (dut_rsp_i !== '0) begin
      $display("CHECK FAILED t=%0t rsp_o expected %h got %h", $time, simd_rsp_t'('0),
               dut_rsp_i);
      ok = 1'b0;
    end
    if (ok) begin
      pass_cnt++;
      $display("test 0 reset: ok");
    end else begin
      fail_cnt++;
      $display("test 0 reset: mismatch");
    end
  endtask

  task automatic check_rsp(input pend_t item);
    alu_op_e op;
    logic    ok;
    op = item.req.op;
    ok = 1'b1;
    if (dut_rsp_i.result !== item.rsp.result) begin
      $display("CHECK FAILED t=%0t rsp_o.result expected %h got %h", $time,
               item.rsp.result, dut_rsp_i.result);
      ok = 1'b0;
    end
    if (dut_rsp_i.vxsat !== item.rsp.vxsat) begin
      $display("CHECK FAILED t=%0t rsp_o.vxsat expected %h got %h", $time,
               item.rsp.vxsat, dut_rsp_i.vxsat);
      ok = 1'b0;
    end
    if (ok) begin
      pass_cnt++;
      $display("test %0d %s ew%0d: ok", item.idx, op.name(), 8 << item.req.vew);
    end else begin
      fail_cnt++;
      $display("test %0d %s ew%0d: mismatch", item.idx, op.name(), 8 << item.req.vew);
    end
  endtask

  // Outputs settle after the rising edge, inputs after the drive delay
  always @(negedge clk_i) begin : p_watch
    pend_t item;
    if (arst_n_i) begin
      if (!reset_done) begin
        check_reset();
        reset_done = 1'b1;
      end
      if (dut_valid_i) begin
        if (pend_q.size() == 0) begin
          $display("t=%0t: valid_o is high but no request is pending", $time);
          fail_cnt++;
        end else begin
          item = pend_q.pop_front();
          check_rsp(item);
        end
        last_rsp = dut_rsp_i;
      end else begin
        // Latency is one cycle, so an older entry is a lost response
        if (pend_q.size() != 0) begin
          item = pend_q.pop_front();
          $display("t=%0t: test %0d got no response one cycle after it was applied",
                   $time, item.idx);
          fail_cnt++;
        end
        if (dut_rsp_i !== last_rsp) begin
          $display("CHECK FAILED t=%0t rsp_o (idle hold) expected %h got %h", $time,
                   last_rsp, dut_rsp_i);
          fail_cnt++;
        end
      end
      if (req_valid_i) begin
        push_cnt++;
        item.idx = 16'(push_cnt);
        item.req = req_i;
        item.rsp = exp_rsp_i;
        pend_q.push_back(item);
      end
      pending = pend_q.size();
    end
  end : p_watch

endmodule

// File: tb/tb_simd_alu.sv
module tb_simd_alu;
  timeunit 1ns;
  timeprecision 1ps;

  import simd_alu_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 4;
  localparam int DRIVE_DLY    = 2;
  localparam int DRAIN_CYCLES = 5;

  typedef struct packed {
    logic       idle;
    simd_req_t  req;
    simd_word_t a;
    simd_word_t b;
    simd_rsp_t  exp;
  } vec_t;

  logic       clk_i;
  logic       arst_n_i;
  logic       valid_i;
  simd_req_t  req_i;
  simd_word_t operand_a_i;
  simd_word_t operand_b_i;
  logic       valid_o;
  simd_rsp_t  rsp_o;
  simd_rsp_t  exp_rsp;
  int         pass_cnt;
  int         fail_cnt;
  int         pending;
  vec_t       vecs[$];
  int         n_tests     = 0;
  logic       table_ready = 1'b0;

  simd_alu simd_alu_i (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .valid_i     ( valid_i     ),
    .req_i       ( req_i       ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .valid_o     ( valid_o     ),
    .rsp_o       ( rsp_o       )
  );

  simd_alu_checker checker_i (
    .clk_i       ( clk_i    ),
    .arst_n_i    ( arst_n_i ),
    .req_valid_i ( valid_i  ),
    .req_i       ( req_i    ),
    .exp_rsp_i   ( exp_rsp  ),
    .dut_valid_i ( valid_o  ),
    .dut_rsp_i   ( rsp_o    ),
    .pass_cnt_o  ( pass_cnt ),
    .fail_cnt_o  ( fail_cnt ),
    .pending_o   ( pending  )
  );

  initial begin : p_clk
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end : p_clk

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_vec(input alu_op_e op, input vew_e vew, input logic vm,
                         input strb_t mask, input simd_word_t a, input simd_word_t b,
                         input simd_word_t res, input strb_t sat);
    vec_t v;
    v.idle       = 1'b0;
    v.req.op     = op;
    v.req.vew    = vew;
    v.req.vm     = vm;
    v.req.mask   = mask;
    v.a          = a;
    v.b          = b;
    v.exp.result = res;
    v.exp.vxsat  = sat;
    vecs.push_back(v);
    n_tests++;
  endtask

  // Idle cycle where the result must hold as operands change
  task automatic add_idle();
    vec_t v;
    v      = '0;
    v.idle = 1'b1;
    v.a    = 64'h5555_5555_5555_5555;
    v.b    = 64'hAAAA_AAAA_AAAA_AAAA;
    vecs.push_back(v);
  endtask

  task automatic build_table();
    // Bitwise and merge
    add_vec(VAND, EW64, 1'b1, 8'h00, 64'hF0F0_1234_FFFF_0000, 64'h0FF0_5678_00FF_FF00,
            64'h00F0_1230_00FF_0000, 8'h00);
    add_vec(VOR, EW64, 1'b1, 8'h00, 64'hF0F0_1234_FFFF_0000, 64'h0FF0_5678_00FF_FF00,
            64'hFFF0_567C_FFFF_FF00, 8'h00);
    add_vec(VXOR, EW64, 1'b1, 8'h00, 64'hF0F0_1234_FFFF_0000, 64'h0FF0_5678_00FF_FF00,
            64'hFF00_444C_FF00_FF00, 8'h00);
    add_vec(VMERGE, EW8, 1'b0, 8'hA5, 64'hA7A6_A5A4_A3A2_A1A0, 64'hB7B6_B5B4_B3B2_B1B0,
            64'hA7B6_A5B4_B3A2_B1A0, 8'h00);
    add_vec(VMERGE, EW32, 1'b0, 8'h1E, 64'h1111_1111_2222_2222, 64'h3333_3333_4444_4444,
            64'h1111_1111_4444_4444, 8'h00);
    add_idle();
    // Modular add, subtract, reverse subtract
    add_vec(VADD, EW8, 1'b1, 8'h00, 64'h01FF_8080_7F10_FF01, 64'h0101_8001_01F0_01FF,
            64'h0200_0081_8000_0000, 8'h00);
    add_vec(VADD, EW16, 1'b1, 8'h00, 64'hFFFF_0001_8000_1234, 64'h0001_FFFF_8000_1111,
            64'h0000_0000_0000_2345, 8'h00);
    add_vec(VADD, EW32, 1'b1, 8'h00, 64'hFFFF_FFFF_1234_5678, 64'h0000_0002_1111_1111,
            64'h0000_0001_2345_6789, 8'h00);
    add_vec(VADD, EW64, 1'b1, 8'h00, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0005,
            64'h0000_0000_0000_0004, 8'h00);
    add_vec(VSUB, EW8, 1'b1, 8'h00, 64'h0102_0304_0506_0708, 64'h0000_1010_FFFF_8000,
            64'hFFFE_0D0C_FAF9_79F8, 8'h00);
    add_vec(VSUB, EW16, 1'b1, 8'h00, 64'h0001_0002_0003_0004, 64'h0000_0002_0005_FFFF,
            64'hFFFF_0000_0002_FFFB, 8'h00);
    add_vec(VSUB, EW32, 1'b1, 8'h00, 64'h0000_0001_0000_0010, 64'h0000_0000_0000_0030,
            64'hFFFF_FFFF_0000_0020, 8'h00);
    add_vec(VSUB, EW64, 1'b1, 8'h00, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_0000,
            64'hFFFF_FFFF_FFFF_FFFF, 8'h00);
    add_vec(VRSUB, EW8, 1'b1, 8'h00, 64'h0010_80FF_0102_0304, 64'h0101_0101_0202_0500,
            64'hFF0F_7FFE_FF00_FE04, 8'h00);
    add_vec(VRSUB, EW16, 1'b1, 8'h00, 64'h0010_0000_1234_FFFF, 64'h0001_0001_0234_FFFF,
            64'h000F_FFFF_1000_0000, 8'h00);
    add_vec(VRSUB, EW32, 1'b1, 8'h00, 64'h0000_0000_0000_0005, 64'h0000_0001_0000_0007,
            64'hFFFF_FFFF_FFFF_FFFE, 8'h00);
    add_vec(VRSUB, EW64, 1'b1, 8'h00, 64'h0000_0000_0000_0003, 64'h0000_0000_0000_0005,
            64'hFFFF_FFFF_FFFF_FFFE, 8'h00);
    // Carry and borrow forms
    add_vec(VADC, EW8, 1'b0, 8'h05, 64'h1010_1010_1010_1010, 64'h2020_2020_2020_2020,
            64'h3030_3030_3031_3031, 8'h00);
    add_vec(VADC, EW16, 1'b1, 8'hFF, 64'h0001_0001_0001_0001, 64'h0002_0002_0002_0002,
            64'h0003_0003_0003_0003, 8'h00);
    add_vec(VSBC, EW16, 1'b0, 8'h04, 64'h0001_0001_0001_0001, 64'h0005_0005_0005_0005,
            64'h0004_0004_0003_0004, 8'h00);
    add_vec(VMADC, EW8, 1'b0, 8'h01, 64'hFF80_0001_7F00_FFFF, 64'h0180_0001_8100_0000,
            64'h0303_0202_0302_0203, 8'h00);
    add_vec(VMSBC, EW32, 1'b1, 8'hFF, 64'h0000_0002_0000_0001, 64'h0000_0001_0000_0001,
            64'h0000_0003_0000_0002, 8'h00);
    // Saturating
    add_vec(VSADDU, EW8, 1'b1, 8'h00, 64'h0102_0304_0506_07F0, 64'h0101_0101_0101_0120,
            64'h0203_0405_0607_08FF, 8'h01);
    add_vec(VSADD, EW16, 1'b1, 8'h00, 64'h7000_8000_0001_FFFF, 64'h2000_FFFF_0002_FFFF,
            64'h7FFF_8000_0003_FFFE, 8'hF0);
    add_vec(VSSUBU, EW32, 1'b1, 8'h00, 64'h0000_0010_0000_0001, 64'h0000_0005_0000_0003,
            64'h0000_0000_0000_0002, 8'hF0);
    add_vec(VSSUB, EW8, 1'b1, 8'h00, 64'h0000_0000_0005_FF01, 64'h0000_0000_0010_7F80,
            64'h0000_0000_000B_7F80, 8'h03);
    add_vec(VSSUB, EW64, 1'b1, 8'h00, 64'h0000_0000_0000_0001, 64'h8000_0000_0000_0000,
            64'h8000_0000_0000_0000, 8'hFF);
    // Shift amounts above the index width
    add_vec(VSLL, EW8, 1'b1, 8'h00, 64'h090A_0F10_11F8_FB08, 64'h8181_8181_8181_8181,
            64'h0204_8081_0281_0881, 8'h00);
    add_vec(VSRL, EW8, 1'b1, 8'h00, 64'h090A_0F10_11F8_FB08, 64'h8181_8181_8181_8181,
            64'h4020_0181_4081_1081, 8'h00);
    add_vec(VSRA, EW8, 1'b1, 8'h00, 64'h090A_0F10_11F8_FB08, 64'h8181_8181_8181_8181,
            64'hC0E0_FF81_C081_F081, 8'h00);
    add_vec(VSLL, EW64, 1'b1, 8'h00, 64'h0000_0000_0000_0044, 64'h8000_0000_0000_000F,
            64'h0000_0000_0000_00F0, 8'h00);
    add_vec(VSRL, EW64, 1'b1, 8'h00, 64'h0000_0000_0000_00C8, 64'h8000_0000_0000_0000,
            64'h0080_0000_0000_0000, 8'h00);
    add_vec(VSRA, EW64, 1'b1, 8'h00, 64'h0000_0000_0000_00C8, 64'h8000_0000_0000_0000,
            64'hFF80_0000_0000_0000, 8'h00);
    // Min and max
    add_vec(VMIN, EW8, 1'b1, 8'h00, 64'h0000_0000_F005_0180, 64'h0000_0000_F105_FF7F,
            64'h0000_0000_F005_FF80, 8'h00);
    add_vec(VMINU, EW8, 1'b1, 8'h00, 64'h0000_0000_F005_0180, 64'h0000_0000_F105_FF7F,
            64'h0000_0000_F005_017F, 8'h00);
    add_vec(VMAXU, EW16, 1'b1, 8'h00, 64'h8000_0001_FFFF_1234, 64'h7FFF_0002_0000_1234,
            64'h8000_0002_FFFF_1234, 8'h00);
    add_vec(VMAX, EW16, 1'b1, 8'h00, 64'h8000_0001_FFFF_1234, 64'h7FFF_0002_0000_1234,
            64'h7FFF_0002_0000_1234, 8'h00);
    // Compare to mask with the mask bit set on elements 3 and 1
    add_vec(VMSEQ, EW16, 1'b0, 8'h44, 64'h0005_8000_0003_0007, 64'h0005_7FFF_0004_0002,
            64'h0003_0000_0002_0000, 8'h00);
    add_vec(VMSNE, EW16, 1'b0, 8'h44, 64'h0005_8000_0003_0007, 64'h0005_7FFF_0004_0002,
            64'h0002_0001_0003_0001, 8'h00);
    add_vec(VMSLT, EW16, 1'b0, 8'h44, 64'h0005_8000_0003_0007, 64'h0005_7FFF_0004_0002,
            64'h0002_0000_0002_0001, 8'h00);
    add_vec(VMSLEU, EW16, 1'b0, 8'h44, 64'h0005_8000_0003_0007, 64'h0005_7FFF_0004_0002,
            64'h0003_0001_0002_0001, 8'h00);
    add_vec(VMSGT, EW16, 1'b0, 8'h44, 64'h0005_8000_0003_0007, 64'h0005_7FFF_0004_0002,
            64'h0002_0001_0003_0000, 8'h00);
  endtask

  task automatic apply_vec(input vec_t v);
    valid_i     = !v.idle;
    req_i       = v.req;
    operand_a_i = v.a;
    operand_b_i = v.b;
    exp_rsp     = v.exp;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and end of run
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_main
    int drain;
    arst_n_i    = 1'b0;
    valid_i     = 1'b0;
    req_i       = '0;
    operand_a_i = '0;
    operand_b_i = '0;
    exp_rsp     = '0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    arst_n_i = 1'b1;
    foreach (vecs[i]) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      apply_vec(vecs[i]);
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    valid_i = 1'b0;
    drain   = 0;
    while (pending != 0 && drain < DRAIN_CYCLES) begin
      @(posedge clk_i);
      drain++;
    end
    if (pending != 0)
      $display("%0d responses still outstanding at end of run", pending);
    else if (pass_cnt + fail_cnt < n_tests + 1)
      $display("only %0d of %0d tests completed", pass_cnt + fail_cnt, n_tests + 1);
    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pending == 0 && pass_cnt == n_tests + 1)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end : p_main

  initial begin : p_watchdog
    wait (table_ready);
    #((vecs.size() + RESET_CYCLES + 20) * CLK_PERIOD);
    $display("TIMEOUT: run did not finish within %0d clock cycles",
             vecs.size() + RESET_CYCLES + 20);
    $display("RESULT: FAIL");
    $finish;
  end : p_watchdog

endmodule
